// File: hw/qm_cfg_pkg.sv
package qm_cfg_pkg;

    // ------------------------------------------------------------------------
    // queue manager sizing
    // ------------------------------------------------------------------------

    localparam int num_prio  = 8;   // priorities per output port.
    localparam int que_depth = 16;  // descriptors per priority.

    localparam int bank_w = 5;      // sram bank number.
    localparam int page_w = 11;     // page pointer inside a bank.
    localparam int cnt_w  = 5;      // extra pages in a run.

    localparam int max_cnt = 31;    // a run never grows past 32 pages.

    localparam int addr_w = bank_w + page_w;    // flat read address.
    localparam int ptr_w  = $clog2(que_depth);  // head and tail index.
    localparam int lvl_w  = $clog2(que_depth + 1);

    // ------------------------------------------------------------------------
    // scalar types
    // ------------------------------------------------------------------------

    typedef logic [$clog2(num_prio)-1:0] prio_t;

    // fill level runs from 0 up to que_depth inclusive.
    typedef logic [lvl_w-1:0] lvl_t;

endpackage

// File: hw/qm_desc_pkg.sv
package qm_desc_pkg;

    // ------------------------------------------------------------------------
    // page-run descriptor
    // ------------------------------------------------------------------------

    // enqueue side sees bank, first page and run count.
    typedef struct packed {
        logic [qm_cfg_pkg::bank_w-1:0] bank;  // sram bank.
        logic [qm_cfg_pkg::page_w-1:0] page;  // first page of the run.
        logic [qm_cfg_pkg::cnt_w-1:0]  cnt;   // pages after the first.
    } desc_fields_t;

    // read side only cares about where to start and how far to go.
    typedef struct packed {
        logic [qm_cfg_pkg::addr_w-1:0] addr;  // bank and page as one address.
        logic [qm_cfg_pkg::cnt_w-1:0]  cnt;
    } desc_addr_t;

    // same 21 bit word, decoded two ways.
    typedef union packed {
        desc_fields_t f;
        desc_addr_t   a;
    } desc_t;

endpackage

// File: hw/qm_ifs.sv
`timescale 1ns/10ps

// ----------------------------------------------------------------------------
// enqueue path, run_merge to que_ram
// ----------------------------------------------------------------------------

interface enq_if;

    logic                vld;        // page strobe.
    qm_cfg_pkg::prio_t   prio;       // target priority.
    logic                append;     // rewrite the newest run in place.
    qm_desc_pkg::desc_t  desc;       // descriptor to store.
    qm_desc_pkg::desc_t  tail_desc;  // newest run of prio.
    logic                tail_ok;    // newest run exists and stays.
    logic                full;       // no room for a new descriptor.

    modport source (
        output vld, prio, append, desc,
        input  tail_desc, tail_ok, full
    );

    modport sink (
        input  vld, prio, append, desc,
        output tail_desc, tail_ok, full
    );

endinterface

// ----------------------------------------------------------------------------
// dequeue path, prio_deq to que_ram
// ----------------------------------------------------------------------------

interface deq_if;

    logic                                                  pop;
    qm_cfg_pkg::prio_t                                     pop_prio;
    logic [qm_cfg_pkg::num_prio-1:0]                       nonempty;
    qm_desc_pkg::desc_t [qm_cfg_pkg::num_prio-1:0]         head_desc;

    modport source (
        output pop, pop_prio,
        input  nonempty, head_desc
    );

    modport sink (
        input  pop, pop_prio,
        output nonempty, head_desc
    );

endinterface

// File: hw/run_merge.sv
`timescale 1ns/10ps

module run_merge (
    input  logic                          enq_vld,
    input  qm_cfg_pkg::prio_t             enq_prio,
    input  logic [qm_cfg_pkg::bank_w-1:0] enq_bank,
    input  logic [qm_cfg_pkg::page_w-1:0] enq_page,
    enq_if.source                         enq
);

    import qm_cfg_pkg::*;
    import qm_desc_pkg::*;

    desc_t             tail;       // newest run of the addressed priority.
    desc_t             new_desc;
    logic [page_w-1:0] next_page;  // page right after the run.
    logic              same_bank;
    logic              in_seq;
    logic              room;
    logic              hit;

    assign tail = enq.tail_desc;

    // ------------------------------------------------------------------------
    // merge test
    // ------------------------------------------------------------------------

    assign next_page = tail.f.page + page_w'(tail.f.cnt) + page_w'(1);

    assign same_bank = (tail.f.bank == enq_bank);
    assign in_seq    = (enq_page == next_page);
    assign room      = (tail.f.cnt < cnt_w'(max_cnt));  // capped at 32 pages.

    // tail_ok already covers empty queues and a same-cycle pop of the last entry.
    assign hit = enq.tail_ok & same_bank & in_seq & room;

    always_comb begin
        if (hit) begin
            new_desc       = tail;
            new_desc.f.cnt = tail.f.cnt + 1'b1;  // one more page.
        end else begin
            new_desc.f.bank = enq_bank;
            new_desc.f.page = enq_page;
            new_desc.f.cnt  = '0;               // single page run.
        end
    end

    // ------------------------------------------------------------------------
    // request to storage
    // ------------------------------------------------------------------------

    assign enq.vld    = enq_vld;
    assign enq.prio   = enq_prio;
    assign enq.append = enq_vld & hit;
    assign enq.desc   = new_desc;

endmodule

// File: hw/que_ram.sv
`timescale 1ns/10ps

module que_ram (
    input  logic                            sys_clk,
    input  logic                            sys_rst_n,
    enq_if.sink                             enq,
    deq_if.sink                             deq,
    output logic                            enq_drop,
    output logic [qm_cfg_pkg::num_prio-1:0] que_busy
);

    import qm_cfg_pkg::*;
    import qm_desc_pkg::*;

    desc_t                            mem [num_prio][que_depth];
    logic [num_prio-1:0][ptr_w-1:0]   wr_ptr;    // next free slot.
    logic [num_prio-1:0][ptr_w-1:0]   rd_ptr;    // oldest entry.
    lvl_t [num_prio-1:0]              lvl;

    logic [num_prio-1:0]              nonempty;
    logic [num_prio-1:0]              full;
    logic [num_prio-1:0]              push;
    logic [num_prio-1:0]              pop;
    logic [ptr_w-1:0]                 tail_idx;  // newest entry of enq.prio.
    logic                             do_new;
    logic                             drop;

    // ------------------------------------------------------------------------
    // status
    // ------------------------------------------------------------------------

    always_comb begin
        for (int p = 0; p < num_prio; p++) begin
            nonempty[p]      = (lvl[p] != '0);
            full[p]          = (lvl[p] == lvl_t'(que_depth));
            deq.head_desc[p] = mem[p][rd_ptr[p]];
        end
    end

    assign deq.nonempty = nonempty;
    assign que_busy     = nonempty;

    // ------------------------------------------------------------------------
    // enqueue side lookups
    // ------------------------------------------------------------------------

    assign tail_idx      = wr_ptr[enq.prio] - 1'b1;
    assign enq.tail_desc = mem[enq.prio][tail_idx];
    assign enq.full      = full[enq.prio];

    // a single entry being popped right now cannot take more pages.
    assign enq.tail_ok = nonempty[enq.prio] &
                         ~(deq.pop && deq.pop_prio == enq.prio &&
                           lvl[enq.prio] == lvl_t'(1));

    assign do_new = enq.vld & ~enq.append & ~enq.full;
    assign drop   = enq.vld & ~enq.append & enq.full;

    always_comb begin
        for (int p = 0; p < num_prio; p++) begin
            push[p] = do_new && (enq.prio == prio_t'(p));
            pop[p]  = deq.pop && (deq.pop_prio == prio_t'(p));
        end
    end

    // ------------------------------------------------------------------------
    // pointers and levels
    // ------------------------------------------------------------------------

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            lvl      <= '0;
            enq_drop <= 1'b0;
        end else begin
            for (int p = 0; p < num_prio; p++) begin
                if (push[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (pop[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                if (push[p] && !pop[p]) begin
                    lvl[p] <= lvl[p] + 1'b1;
                end else if (pop[p] && !push[p]) begin
                    lvl[p] <= lvl[p] - 1'b1;
                end
            end
            enq_drop <= drop;  // one cycle after the strobe.
        end
    end

    // descriptor storage.
    always_ff @(posedge sys_clk) begin
        if (enq.vld && enq.append) begin
            mem[enq.prio][tail_idx] <= enq.desc;          // grow the run in place.
        end else if (do_new) begin
            mem[enq.prio][wr_ptr[enq.prio]] <= enq.desc;
        end
    end

endmodule

// File: hw/prio_deq.sv
`timescale 1ns/10ps

module prio_deq (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    input  logic                          deq_req,
    deq_if.source                         deq,
    output logic                          deq_vld,
    output qm_cfg_pkg::prio_t             deq_prio,
    output logic [qm_cfg_pkg::addr_w-1:0] deq_addr,
    output logic [qm_cfg_pkg::cnt_w-1:0]  deq_cnt
);

    import qm_cfg_pkg::*;
    import qm_desc_pkg::*;

    prio_t sel;      // lowest non-empty priority.
    logic  any;
    logic  take;
    desc_t head;

    // ------------------------------------------------------------------------
    // strict priority pick
    // ------------------------------------------------------------------------

    always_comb begin
        sel = '0;
        // walk down so the lowest index wins.
        for (int p = num_prio - 1; p >= 0; p--) begin
            if (deq.nonempty[p]) begin
                sel = prio_t'(p);
            end
        end
    end

    assign any  = |deq.nonempty;
    assign take = deq_req & any;   // requests on empty queues are dropped.
    assign head = deq.head_desc[sel];

    assign deq.pop      = take;
    assign deq.pop_prio = sel;

    // ------------------------------------------------------------------------
    // registered response
    // ------------------------------------------------------------------------

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            deq_vld <= 1'b0;
        end else begin
            deq_vld <= take;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            deq_prio <= sel;
            deq_addr <= head.a.addr;   // bank and page as one read address.
            deq_cnt  <= head.a.cnt;
        end
    end

endmodule

// File: hw/desc_queue_mgr.sv
`timescale 1ns/10ps

module desc_queue_mgr (
    input  logic                            sys_clk,
    input  logic                            sys_rst_n,

    // enqueue strobe, one page per cycle.
    input  logic                            enq_vld,
    input  qm_cfg_pkg::prio_t               enq_prio,
    input  logic [qm_cfg_pkg::bank_w-1:0]   enq_bank,
    input  logic [qm_cfg_pkg::page_w-1:0]   enq_page,
    output logic                            enq_drop,

    // dequeue request and response.
    input  logic                            deq_req,
    output logic                            deq_vld,
    output qm_cfg_pkg::prio_t               deq_prio,
    output logic [qm_cfg_pkg::addr_w-1:0]   deq_addr,
    output logic [qm_cfg_pkg::cnt_w-1:0]    deq_cnt,

    output logic [qm_cfg_pkg::num_prio-1:0] que_busy
);

    import qm_cfg_pkg::*;

    logic [num_prio-1:0] busy;  // per priority non-empty.

    // ------------------------------------------------------------------------
    // internal buses
    // ------------------------------------------------------------------------

    enq_if enq_bus ();
    deq_if deq_bus ();

    // ------------------------------------------------------------------------
    // blocks
    // ------------------------------------------------------------------------

    run_merge u_run_merge (
        .enq_vld  (enq_vld),
        .enq_prio (enq_prio),
        .enq_bank (enq_bank),
        .enq_page (enq_page),
        .enq      (enq_bus.source)
    );

    que_ram u_que_ram (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .enq       (enq_bus.sink),
        .deq       (deq_bus.sink),
        .enq_drop  (enq_drop),
        .que_busy  (busy)
    );

    prio_deq u_prio_deq (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .deq_req   (deq_req),
        .deq       (deq_bus.source),
        .deq_vld   (deq_vld),
        .deq_prio  (deq_prio),
        .deq_addr  (deq_addr),
        .deq_cnt   (deq_cnt)
    );

    assign que_busy = busy;

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic sys_clk
);

    localparam real half_period = 2.0;  // 4 ns period.

    initial begin
        sys_clk = 1'b0;
    end

    always #(half_period) sys_clk = ~sys_clk;

endmodule

// File: dv/desc_queue_mgr_sva.sv
`timescale 1ns/10ps

module desc_queue_mgr_sva (
    input logic                            sys_clk,
    input logic                            sys_rst_n,
    input logic                            deq_req,
    input logic                            pop,
    input qm_cfg_pkg::prio_t               pop_prio,
    input logic [qm_cfg_pkg::num_prio-1:0] nonempty,
    input logic                            deq_vld
);

    // response only in the cycle after a request.
    vld_after_req: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        deq_vld |-> $past(deq_req)
    ) else $error("deq_vld without a request one cycle earlier");

    // a pop always lands on a queue that holds an entry.
    no_empty_pop: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        pop |-> nonempty[pop_prio]
    ) else $error("pop issued to an empty queue");

    vld_low_in_reset: assert property (
        @(posedge sys_clk) !sys_rst_n |-> !deq_vld
    ) else $error("deq_vld high during reset");

endmodule

bind prio_deq desc_queue_mgr_sva prio_deq_sva_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .deq_req   (deq_req),
    .pop       (deq.pop),
    .pop_prio  (deq.pop_prio),
    .nonempty  (deq.nonempty),
    .deq_vld   (deq_vld)
);

// File: dv/desc_queue_mgr_tb.sv
`timescale 1ns/10ps

module desc_queue_mgr_tb;

    import qm_cfg_pkg::*;
    import qm_desc_pkg::*;

    localparam int max_steps  = 64;
    localparam int rst_cycles = 16;

    // step opcodes, top nibble of each golden word.
    localparam logic [3:0] op_enq   = 4'h1;
    localparam logic [3:0] op_deq   = 4'h2;
    localparam logic [3:0] op_drop  = 4'h3;   // enqueue into a full queue.
    localparam logic [3:0] op_empty = 4'h4;   // request with nothing queued.
    localparam logic [3:0] op_race  = 4'h5;   // pop plus next page, same cycle.
    localparam logic [3:0] op_end   = 4'hf;

    logic                sys_clk;
    logic                sys_rst_n;
    logic                enq_vld;
    prio_t               enq_prio;
    logic [bank_w-1:0]   enq_bank;
    logic [page_w-1:0]   enq_page;
    logic                enq_drop;
    logic                deq_req;
    logic                deq_vld;
    prio_t               deq_prio;
    logic [addr_w-1:0]   deq_addr;
    logic [cnt_w-1:0]    deq_cnt;
    logic [num_prio-1:0] que_busy;

    logic [47:0] steps [max_steps];
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          n_checks = 0;

    tb_clk_gen clk_gen_i (.sys_clk(sys_clk));

    desc_queue_mgr desc_queue_mgr_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .enq_vld   (enq_vld),
        .enq_prio  (enq_prio),
        .enq_bank  (enq_bank),
        .enq_page  (enq_page),
        .enq_drop  (enq_drop),
        .deq_req   (deq_req),
        .deq_vld   (deq_vld),
        .deq_prio  (deq_prio),
        .deq_addr  (deq_addr),
        .deq_cnt   (deq_cnt),
        .que_busy  (que_busy)
    );

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic prio_check(input prio_t got, input prio_t exp);
        n_checks++;
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: deq_prio is %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic desc_check(input desc_t got, input desc_t exp);
        n_checks++;
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: bank %0d page 0x%03h cnt %0d, expected %0d 0x%03h %0d",
                               $time, got.f.bank, got.f.page, got.f.cnt,
                               exp.f.bank, exp.f.page, exp.f.cnt));
        end
    endtask

    // ------------------------------------------------------------------------
    // one golden step, repeated rep times
    // ------------------------------------------------------------------------

    task automatic run_step(input logic [47:0] w);
        logic [3:0]        op;
        prio_t             prio;
        logic [bank_w-1:0] bank;
        logic [page_w-1:0] page;
        logic [cnt_w-1:0]  cnt;
        int                rep;
        int                stride;
        desc_t             exp_d;
        desc_t             got_d;
        op     = w[47:44];
        prio   = prio_t'(w[43:40]);
        bank   = bank_w'(w[39:32]);
        page   = page_w'(w[31:20]);
        cnt    = cnt_w'(w[19:12]);
        rep    = (op == op_race) ? 1 : int'(w[11:4]);
        stride = int'(w[3:0]);
        for (int i = 0; i < rep; i++) begin
            enq_vld  = (op == op_enq || op == op_drop || op == op_race);
            deq_req  = (op == op_deq || op == op_empty || op == op_race);
            enq_prio = prio;
            enq_bank = bank;
            if (op == op_race) begin
                enq_page = page + page_w'(cnt) + page_w'(1);  // page that would extend the run.
            end else begin
                enq_page = page + page_w'(i * stride);
            end
            @(posedge sys_clk);
            #1;
            enq_vld = 1'b0;
            deq_req = 1'b0;
            if (op == op_enq || op == op_drop || op == op_race) begin
                bit_check("enq_drop", enq_drop, op == op_drop);
                bit_check("que_busy", que_busy[prio], 1'b1);  // queue holds the page.
            end
            if (op == op_deq || op == op_empty || op == op_race) begin
                bit_check("deq_vld", deq_vld, op != op_empty);
            end
            if (op == op_empty) begin
                bit_check("que_busy", |que_busy, 1'b0);
            end
            if (op == op_deq || op == op_race) begin
                exp_d.f.bank = bank;
                exp_d.f.page = page + page_w'(i * stride);
                exp_d.f.cnt  = cnt;
                got_d.a.addr = deq_addr;
                got_d.a.cnt  = deq_cnt;
                prio_check(deq_prio, prio);
                desc_check(got_d, exp_d);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // timeout
    // ------------------------------------------------------------------------

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_run($sformatf("timeout, the run went past %0d cycles", cycle_limit));
        end
    end

    initial begin
        logic [31:0] seed_val;
        int          n_steps;
        int          n_items;
        int          gap;
        bit          scan_done;
        sys_rst_n = 1'b1;
        enq_vld   = 1'b0;
        enq_prio  = '0;
        enq_bank  = '0;
        enq_page  = '0;
        deq_req   = 1'b0;
        seed_val  = $urandom(71671);
        for (int s = 0; s < max_steps; s++) begin
            steps[s] = 'x;
        end
        $readmemh("dv/qm_golden.txt", steps);

        // count steps and pages to size the timeout.
        n_steps   = 0;
        n_items   = 0;
        scan_done = 1'b0;
        while (!scan_done) begin
            if (n_steps == max_steps || $isunknown(steps[n_steps])) begin
                stop_run("golden file is missing, malformed or has no end marker");
            end else if (steps[n_steps][47:44] == op_end) begin
                scan_done = 1'b1;
            end else begin
                n_items += int'(steps[n_steps][11:4]) + 1;
                n_steps++;
            end
        end
        cycle_limit = rst_cycles + 50 + 2 * n_items + 3 * n_steps;

        #1 sys_rst_n = 1'b0;
        repeat (rst_cycles) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;
        bit_check("deq_vld after reset", deq_vld, 1'b0);
        bit_check("enq_drop after reset", enq_drop, 1'b0);
        bit_check("que_busy after reset", |que_busy, 1'b0);

        for (int s = 0; s < n_steps; s++) begin
            run_step(steps[s]);
            gap = $urandom % 3;  // idle cycles between steps.
            repeat (gap) begin
                @(posedge sys_clk);
                #1;
            end
        end

        if (n_checks > 3) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stop_run("golden file held no checks to run");
        end
    end

endmodule

// File: dv/qm_golden.txt
// columns op_prio_bank_page_cnt_rep_stride in hex, page steps by stride per repeat.
// op 0 idle, 1 enqueue, 2 dequeue with expected result, 3 enqueue expecting a drop,
// op 4 dequeue on empty queues, 5 dequeue while the next page enqueues, f end.
0_0_00_000_00_02_0
4_0_00_000_00_01_0
// three sequential pages merge into one run.
1_3_02_00a_00_03_1
2_3_02_00a_02_01_0
// bank and page breaks, fifo order within one priority.
1_1_04_100_00_02_1
1_1_05_102_00_01_0
1_1_05_110_00_01_0
2_1_04_100_01_01_0
2_1_05_102_00_01_0
2_1_05_110_00_01_0
// strict priority across 5, 2 and 7.
1_5_01_020_00_01_0
1_2_01_030_00_01_0
1_7_01_040_00_01_0
2_2_01_030_00_01_0
2_5_01_020_00_01_0
2_7_01_040_00_01_0
// 33 sequential pages, run capped at count 31.
1_4_03_200_00_21_1
2_4_03_200_1f_01_0
2_4_03_220_00_01_0
// 17 scattered pages, the last one dropped.
1_6_06_000_00_10_2
3_6_06_020_00_01_0
2_6_06_000_00_10_2
4_0_00_000_00_01_0
// pop and enqueue on a one entry queue.
1_0_07_300_00_01_0
5_0_07_300_00_01_0
2_0_07_301_00_01_0
4_0_00_000_00_02_0
f_0_00_000_00_00_0

// File: sources.f
hw/qm_cfg_pkg.sv
hw/qm_desc_pkg.sv
hw/qm_ifs.sv
hw/run_merge.sv
hw/que_ram.sv
hw/prio_deq.sv
hw/desc_queue_mgr.sv
dv/tb_clk_gen.sv
dv/desc_queue_mgr_sva.sv
dv/desc_queue_mgr_tb.sv

// File: Bender.yml
package:
  name: desc_queue_mgr

sources:
  - files:
      - hw/qm_cfg_pkg.sv
      - hw/qm_desc_pkg.sv
      - hw/qm_ifs.sv
      - hw/run_merge.sv
      - hw/que_ram.sv
      - hw/prio_deq.sv
      - hw/desc_queue_mgr.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/desc_queue_mgr_sva.sv
      - dv/desc_queue_mgr_tb.sv
